// ==== logic/adc_pkg.sv ====
`default_nettype none

package adc_pkg;

    // ------------------------------
    // Converter geometry
    // ------------------------------
    localparam int ADC_BITS      = 16;                        // LTC1864 result width
    localparam int CHAN_PER_QUAD = 4;                         // Channels on one board
    localparam int NUM_QUAD      = 2;                         // Boards sharing sclk/conv
    localparam int NUM_CHAN      = CHAN_PER_QUAD * NUM_QUAD;  // Channels per chain

    // One conversion result
    typedef logic [ADC_BITS-1:0] adc_word_t;

    // ------------------------------
    // Register read bus
    // ------------------------------
    localparam int REG_BITS = 32;
    typedef logic [REG_BITS-1:0] reg_word_t;

    // Frame counters fill one half of a read word
    localparam int FRAME_CNT_BITS = REG_BITS / 2;

    // Read address layout
    localparam int SPACE_MSB = 15;  // Address space
    localparam int SPACE_LSB = 12;
    localparam int CHAN_MSB  = 7;   // Channel, 1 based for ADC data
    localparam int CHAN_LSB  = 4;
    localparam int OFF_MSB   = 3;   // Register offset within a channel
    localparam int OFF_LSB   = 0;

    typedef logic [CHAN_MSB-CHAN_LSB:0] chan_t;

    // Field values
    localparam logic [SPACE_MSB-SPACE_LSB:0] ADDR_MAIN       = 4'd0;
    localparam logic [OFF_MSB-OFF_LSB:0]     OFF_ADC_DATA    = 4'd0;  // Pot above current
    localparam logic [OFF_MSB-OFF_LSB:0]     OFF_FRAME_COUNT = 4'd1;  // Channel 0 only

endpackage

`default_nettype wire

// ==== logic/ltc1864_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module ltc1864_capture #(
    parameter int SCLK_DIV    = 4,  // sysclk cycles per sclk half period
    parameter int CONV_CYCLES = 8   // Convert strobe width
) (
    input  logic                sysclk,
    input  logic                rst,
    input  logic [adc_pkg::NUM_CHAN-1:0] miso,        // One line per converter
    output logic                sclk,
    output logic                conv,
    output logic                frame_valid,         // Words complete this cycle
    output adc_pkg::adc_word_t  words [adc_pkg::NUM_CHAN]
);

    // ------------------------------
    // Sequencer state
    // ------------------------------
    localparam logic [2:0] ST_IDLE = 3'd0;  // Held in reset
    localparam logic [2:0] ST_CONV = 3'd1;  // Convert strobe high
    localparam logic [2:0] ST_LOW  = 3'd2;  // sclk low phase
    localparam logic [2:0] ST_HIGH = 3'd3;  // sclk high phase
    localparam logic [2:0] ST_DONE = 3'd4;  // frame_valid cycle

    localparam int CNT_MAX = (CONV_CYCLES > SCLK_DIV) ? CONV_CYCLES : SCLK_DIV;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam int BIT_W   = $clog2(adc_pkg::ADC_BITS);

    logic [2:0]       state;
    logic [CNT_W-1:0] phase_cnt;   // Cycles within conv or an sclk half period
    logic [BIT_W-1:0] bit_cnt;     // sclk periods done in this frame
    logic             conv_last;
    logic             half_last;
    logic             shift_en;

    assign conv_last = (phase_cnt == CNT_W'(CONV_CYCLES - 1));
    assign half_last = (phase_cnt == CNT_W'(SCLK_DIV - 1));

    // Sample point is the sclk rise
    assign shift_en = (state == ST_LOW) && half_last;

    // ------------------------------
    // Frame sequencer
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state       <= ST_IDLE;
            phase_cnt   <= '0;
            bit_cnt     <= '0;
            conv        <= 1'b0;
            sclk        <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;  // Single cycle pulse
            case (state)
                ST_IDLE: begin
                    state     <= ST_CONV;
                    conv      <= 1'b1;
                    phase_cnt <= '0;
                end
                ST_CONV: begin
                    if (conv_last) begin
                        state     <= ST_LOW;   // ADC now drives its MSB
                        conv      <= 1'b0;
                        phase_cnt <= '0;
                        bit_cnt   <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                ST_LOW: begin
                    if (half_last) begin
                        state     <= ST_HIGH;
                        sclk      <= 1'b1;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                ST_HIGH: begin
                    if (half_last) begin
                        sclk      <= 1'b0;      // ADC shifts out next bit after this
                        phase_cnt <= '0;
                        if (bit_cnt == BIT_W'(adc_pkg::ADC_BITS - 1)) begin
                            state       <= ST_DONE;
                            frame_valid <= 1'b1;
                        end else begin
                            state   <= ST_LOW;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    state <= ST_CONV;  // Free running, next frame right away
                    conv  <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                    conv  <= 1'b0;
                    sclk  <= 1'b0;
                end
            endcase
        end
    end

    // ------------------------------
    // Shift registers, MSB first
    // ------------------------------
    // Last shift is at the 16th rise, so words hold through frame_valid
    always_ff @(posedge sysclk) begin
        if (shift_en) begin
            for (int i = 0; i < adc_pkg::NUM_CHAN; i++) begin
                words[i] <= {words[i][adc_pkg::ADC_BITS-2:0], miso[i]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/adc_feedback_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_feedback_regs (
    input  logic               sysclk,
    input  logic               rst,

    // Pot chain
    input  logic               pot_valid,
    input  adc_pkg::adc_word_t pot_words [adc_pkg::NUM_CHAN],

    // Motor current chain
    input  logic               cur_valid,
    input  adc_pkg::adc_word_t cur_words [adc_pkg::NUM_CHAN],

    // Latest complete frames
    output adc_pkg::adc_word_t pot_fb [adc_pkg::NUM_CHAN],
    output adc_pkg::adc_word_t cur_fb [adc_pkg::NUM_CHAN],
    output logic [adc_pkg::FRAME_CNT_BITS-1:0] pot_frames,  // Wraps
    output logic [adc_pkg::FRAME_CNT_BITS-1:0] cur_frames
);

    // ------------------------------
    // Pot feedback
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < adc_pkg::NUM_CHAN; i++) begin
                pot_fb[i] <= '0;
            end
            pot_frames <= '0;
        end else if (pot_valid) begin
            pot_fb     <= pot_words;          // Whole frame in one edge
            pot_frames <= pot_frames + 1'b1;
        end
    end

    // ------------------------------
    // Current feedback
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < adc_pkg::NUM_CHAN; i++) begin
                cur_fb[i] <= '0;
            end
            cur_frames <= '0;
        end else if (cur_valid) begin
            cur_fb     <= cur_words;
            cur_frames <= cur_frames + 1'b1;
        end
    end

    // Chains share parameters but have no common strobe,
    // so each counter only follows its own valid

endmodule

`default_nettype wire

// ==== logic/adc_reg_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_reg_read (
    input  logic               sysclk,
    input  logic               rst,
    input  logic [15:0]        reg_raddr,
    input  adc_pkg::adc_word_t pot_fb [adc_pkg::NUM_CHAN],
    input  adc_pkg::adc_word_t cur_fb [adc_pkg::NUM_CHAN],
    input  logic [adc_pkg::FRAME_CNT_BITS-1:0] pot_frames,
    input  logic [adc_pkg::FRAME_CNT_BITS-1:0] cur_frames,
    output adc_pkg::reg_word_t reg_rdata    // One cycle after reg_raddr
);

    localparam int IDX_W = $clog2(adc_pkg::NUM_CHAN);

    // ------------------------------
    // Address decode
    // ------------------------------
    logic [adc_pkg::SPACE_MSB-adc_pkg::SPACE_LSB:0] space;
    logic [adc_pkg::OFF_MSB-adc_pkg::OFF_LSB:0]     offset;
    adc_pkg::chan_t                                  chan;
    logic [IDX_W-1:0]                                chan_idx;
    logic                                            is_main;
    logic                                            chan_ok;   // Channel 1..NUM_CHAN
    adc_pkg::reg_word_t                              rd_next;

    assign space    = reg_raddr[adc_pkg::SPACE_MSB:adc_pkg::SPACE_LSB];
    assign chan     = reg_raddr[adc_pkg::CHAN_MSB:adc_pkg::CHAN_LSB];
    assign offset   = reg_raddr[adc_pkg::OFF_MSB:adc_pkg::OFF_LSB];
    assign chan_idx = IDX_W'(chan - adc_pkg::chan_t'(1));  // Channels are 1 based
    assign is_main  = (space == adc_pkg::ADDR_MAIN);
    assign chan_ok  = (chan != '0) && (chan <= adc_pkg::chan_t'(adc_pkg::NUM_CHAN));

    // ------------------------------
    // Read mux
    // ------------------------------
    always_comb begin
        rd_next = '0;  // Unmapped reads
        if (is_main && chan_ok && (offset == adc_pkg::OFF_ADC_DATA)) begin
            rd_next = {pot_fb[chan_idx], cur_fb[chan_idx]};  // Pot high, current low
        end else if (is_main && (chan == '0) && (offset == adc_pkg::OFF_FRAME_COUNT)) begin
            rd_next = {pot_frames, cur_frames};
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/qla_adc_feedback.sv ====
`timescale 1ns/1ps
`default_nettype none

module qla_adc_feedback #(
    parameter int SCLK_DIV    = 4,  // Serial clock half period in sysclk cycles
    parameter int CONV_CYCLES = 8   // Convert strobe width in sysclk cycles
) (
    input  logic        sysclk,
    input  logic        rst,

    // Converter MISO lines, bits 0..3 board 1, bits 4..7 board 2
    input  logic [adc_pkg::NUM_CHAN-1:0] pot_miso,
    input  logic [adc_pkg::NUM_CHAN-1:0] cur_miso,

    // Shared strobes per chain
    output logic        sclk_pot,
    output logic        conv_pot,
    output logic        sclk_cur,
    output logic        conv_cur,

    // Register read bus
    input  logic [15:0] reg_raddr,
    output adc_pkg::reg_word_t reg_rdata
);

    // Capture to store
    logic               pot_valid;
    logic               cur_valid;
    adc_pkg::adc_word_t pot_words [adc_pkg::NUM_CHAN];
    adc_pkg::adc_word_t cur_words [adc_pkg::NUM_CHAN];

    // Store to reader
    adc_pkg::adc_word_t pot_fb [adc_pkg::NUM_CHAN];
    adc_pkg::adc_word_t cur_fb [adc_pkg::NUM_CHAN];
    logic [adc_pkg::FRAME_CNT_BITS-1:0] pot_frames;
    logic [adc_pkg::FRAME_CNT_BITS-1:0] cur_frames;

    // ------------------------------
    // Conversion chains
    // ------------------------------
    ltc1864_capture #(
        .SCLK_DIV    (SCLK_DIV),
        .CONV_CYCLES (CONV_CYCLES)
    ) u_pot_capture (
        .sysclk      (sysclk),
        .rst         (rst),
        .miso        (pot_miso),
        .sclk        (sclk_pot),
        .conv        (conv_pot),
        .frame_valid (pot_valid),
        .words       (pot_words)
    );

    ltc1864_capture #(
        .SCLK_DIV    (SCLK_DIV),
        .CONV_CYCLES (CONV_CYCLES)
    ) u_cur_capture (
        .sysclk      (sysclk),
        .rst         (rst),
        .miso        (cur_miso),
        .sclk        (sclk_cur),
        .conv        (conv_cur),
        .frame_valid (cur_valid),
        .words       (cur_words)
    );

    // ------------------------------
    // Feedback store and read port
    // ------------------------------
    adc_feedback_regs u_fb_regs (
        .sysclk     (sysclk),
        .rst        (rst),
        .pot_valid  (pot_valid),
        .pot_words  (pot_words),
        .cur_valid  (cur_valid),
        .cur_words  (cur_words),
        .pot_fb     (pot_fb),
        .cur_fb     (cur_fb),
        .pot_frames (pot_frames),
        .cur_frames (cur_frames)
    );

    adc_reg_read u_reg_read (
        .sysclk     (sysclk),
        .rst        (rst),
        .reg_raddr  (reg_raddr),
        .pot_fb     (pot_fb),
        .cur_fb     (cur_fb),
        .pot_frames (pot_frames),
        .cur_frames (cur_frames),
        .reg_rdata  (reg_rdata)
    );

endmodule

`default_nettype wire

// ==== bench/ltc1864_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ltc1864_model (
    input  logic               sysclk,
    input  logic               conv_pot,
    input  logic               sclk_pot,
    input  logic               conv_cur,
    input  logic               sclk_cur,
    input  adc_pkg::reg_word_t patterns [2*adc_pkg::NUM_CHAN],  // Pot high, current low
    output logic [adc_pkg::NUM_CHAN-1:0] pot_miso,
    output logic [adc_pkg::NUM_CHAN-1:0] cur_miso
);

    localparam int N = adc_pkg::NUM_CHAN;

    // Chain 0 is pot, chain 1 is current
    logic [1:0]         conv_in;
    logic [1:0]         sclk_in;
    logic [1:0]         conv_q  = '0;
    logic [1:0]         sclk_q  = '0;
    int                 frames  [2] = '{0, 0};           // conv falls seen
    int                 bit_pos [2] = '{15, 15};         // Bit on MISO now
    adc_pkg::adc_word_t sr      [2][N] = '{default: '0};
    logic [N-1:0]       miso    [2] = '{default: '0};
    adc_pkg::reg_word_t word;

    assign conv_in  = {conv_cur, conv_pot};
    assign sclk_in  = {sclk_cur, sclk_pot};
    assign pot_miso = miso[0];
    assign cur_miso = miso[1];

    // Strobes move on the rising edge, so both are settled here
    always @(negedge sysclk) begin
        for (int c = 0; c < 2; c++) begin
            if (conv_q[c] && !conv_in[c]) begin
                for (int i = 0; i < N; i++) begin
                    word     = patterns[((frames[c] == 0) ? 0 : N) + i];  // Frame 1 repeats
                    sr[c][i] = (c == 0) ? word[31:16] : word[15:0];
                end
                frames[c]++;
                bit_pos[c] = adc_pkg::ADC_BITS - 1;     // MSB out before first rise
            end else if (sclk_q[c] && !sclk_in[c] && bit_pos[c] > 0) begin
                bit_pos[c]--;                           // Next bit after the fall
            end
            for (int i = 0; i < N; i++) begin
                miso[c][i] = sr[c][i][bit_pos[c]];
            end
            conv_q[c] = conv_in[c];
            sclk_q[c] = sclk_in[c];
        end
    end

endmodule

`default_nettype wire

// ==== bench/qla_adc_feedback_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module qla_adc_feedback_sva (
    input logic               sysclk,
    input logic               rst,
    input logic               conv_pot,
    input logic               sclk_pot,
    input logic               conv_cur,
    input logic               sclk_cur,
    input adc_pkg::reg_word_t reg_rdata
);

    // ------------------------------
    // Serial strobes
    // ------------------------------
    a_pot_no_overlap: assert property (@(posedge sysclk) disable iff (rst)
        !(conv_pot && sclk_pot)) else $error("conv_pot and sclk_pot high together");
    a_cur_no_overlap: assert property (@(posedge sysclk) disable iff (rst)
        !(conv_cur && sclk_cur)) else $error("conv_cur and sclk_cur high together");

    // sclk low phase always follows conv
    a_pot_sclk_low: assert property (@(posedge sysclk) disable iff (rst)
        conv_pot |=> !sclk_pot) else $error("sclk_pot rose right after conv_pot");
    a_cur_sclk_low: assert property (@(posedge sysclk) disable iff (rst)
        conv_cur |=> !sclk_cur) else $error("sclk_cur rose right after conv_cur");

    // Read port
    a_rdata_reset: assert property (@(posedge sysclk)
        rst |=> (reg_rdata == '0)) else $error("reg_rdata not cleared by reset");

endmodule

bind qla_adc_feedback qla_adc_feedback_sva u_sva (
    .sysclk    (sysclk),
    .rst       (rst),
    .conv_pot  (conv_pot),
    .sclk_pot  (sclk_pot),
    .conv_cur  (conv_cur),
    .sclk_cur  (sclk_cur),
    .reg_rdata (reg_rdata)
);

`default_nettype wire

// ==== bench/tb_qla_adc_feedback.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_qla_adc_feedback;

    localparam int SEED           = 75;
    localparam int HALF_PERIOD    = 10;                     // 20 ns sysclk
    localparam int SCLK_DIV       = 4;                      // DUT defaults
    localparam int CONV_CYCLES    = 8;
    localparam int FRAME_CYCLES   = CONV_CYCLES + 32 * SCLK_DIV + 1;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 200;
    localparam int N              = adc_pkg::NUM_CHAN;

    logic               sysclk = 1'b0;
    logic               rst;
    logic [15:0]        reg_raddr;
    adc_pkg::reg_word_t reg_rdata;
    logic [N-1:0]       pot_miso;
    logic [N-1:0]       cur_miso;
    logic               sclk_pot;
    logic               conv_pot;
    logic               sclk_cur;
    logic               conv_cur;

    adc_pkg::reg_word_t patterns [2*N];     // Frame 0, then frame 1
    adc_pkg::reg_word_t rdata;
    int                 order [N];          // Channel read order, 1 based
    int                 error_count     = 0;
    int                 errors_at_start = 0;
    int                 tests_passed    = 0;
    int                 tests_failed    = 0;
    int                 test_num        = 0;
    int                 cycle_count     = 0;

    // Strobe tracking, index 0 pot chain, 1 current chain
    logic [1:0]         conv_now;
    logic [1:0]         sclk_now;
    logic [1:0]         conv_q          = '0;
    logic [1:0]         sclk_q          = '0;
    int                 conv_rises [2]  = '{0, 0};
    int                 last_rise  [2]  = '{0, 0};   // Cycle of the latest conv rise
    int                 sclk_rises [2]  = '{0, 0};   // Since the latest conv rise
    string              conv_name  [2]  = '{"conv_pot", "conv_cur"};
    string              sclk_name  [2]  = '{"sclk_pot", "sclk_cur"};

    always #(HALF_PERIOD) sysclk = ~sysclk;

    qla_adc_feedback #(
        .SCLK_DIV    (SCLK_DIV),
        .CONV_CYCLES (CONV_CYCLES)
    ) i_dut (
        .sysclk    (sysclk),
        .rst       (rst),
        .pot_miso  (pot_miso),
        .cur_miso  (cur_miso),
        .sclk_pot  (sclk_pot),
        .conv_pot  (conv_pot),
        .sclk_cur  (sclk_cur),
        .conv_cur  (conv_cur),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata)
    );

    ltc1864_model u_adc_model (
        .sysclk   (sysclk),
        .conv_pot (conv_pot),
        .sclk_pot (sclk_pot),
        .conv_cur (conv_cur),
        .sclk_cur (sclk_cur),
        .patterns (patterns),
        .pot_miso (pot_miso),
        .cur_miso (cur_miso)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    // ------------------------------
    // Frame tracking and timeout
    // ------------------------------
    assign conv_now = {conv_cur, conv_pot};
    assign sclk_now = {sclk_cur, sclk_pot};

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        conv_q      <= conv_now;
        sclk_q      <= sclk_now;
        for (int c = 0; c < 2; c++) begin
            if (sclk_now[c] && !sclk_q[c]) begin
                sclk_rises[c] <= sclk_rises[c] + 1;
            end
            if (conv_now[c] && !conv_q[c]) begin
                if (conv_rises[c] > 0) begin  // One whole frame since the last rise
                    check_value($sformatf("%s frame length", conv_name[c]),
                                32'(cycle_count - last_rise[c]), 32'(FRAME_CYCLES));
                    check_value($sformatf("%s rises per frame", sclk_name[c]),
                                32'(sclk_rises[c]), 32'(adc_pkg::ADC_BITS));
                end
                conv_rises[c] <= conv_rises[c] + 1;
                last_rise[c]  <= cycle_count;
                sclk_rises[c] <= 0;
            end
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] make_addr(input logic [3:0] space, input int chan,
                                              input logic [3:0] offset);
        logic [15:0] addr;
        addr = '0;
        addr[adc_pkg::SPACE_MSB:adc_pkg::SPACE_LSB] = space;
        addr[adc_pkg::CHAN_MSB:adc_pkg::CHAN_LSB]   = adc_pkg::chan_t'(chan);
        addr[adc_pkg::OFF_MSB:adc_pkg::OFF_LSB]     = offset;
        return addr;
    endfunction

    task automatic read_reg(input logic [15:0] addr, output adc_pkg::reg_word_t data);
        @(negedge sysclk);
        reg_raddr = addr;
        @(posedge sysclk);                    // Registered read data
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    task automatic read_expect(input string name, input logic [15:0] addr,
                               input logic [31:0] expected);
        adc_pkg::reg_word_t data;
        read_reg(addr, data);
        check_value(name, data, expected);
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", test_num, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    // Pot chain sets the frame pace
    task automatic wait_conv_rises(input int count);
        while (conv_rises[0] < count) @(negedge sysclk);
    endtask

    // Fisher-Yates over channels 1..N
    task automatic shuffle_channels();
        int j;
        int tmp;
        for (int i = 0; i < N; i++) begin
            order[i] = i + 1;
        end
        for (int i = N - 1; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        rst       = 1'b1;
        reg_raddr = '0;
        void'($urandom(SEED));
        $readmemh("bench/adc_patterns.hex", patterns);
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;

        // Store still empty in the first frame
        for (int ch = 1; ch <= N; ch++) begin
            read_expect($sformatf("reg_rdata ch%0d", ch),
                        make_addr(adc_pkg::ADDR_MAIN, ch, adc_pkg::OFF_ADC_DATA), '0);
        end
        read_expect("frame count", make_addr(adc_pkg::ADDR_MAIN, 0, adc_pkg::OFF_FRAME_COUNT), '0);
        if (conv_rises[0] > 1) begin
            error_count++;
            $display("Reset reads ran past the end of the first frame");
        end
        finish_test("reset values");

        wait_conv_rises(2);                   // Frame 0 stored
        shuffle_channels();
        for (int i = 0; i < N; i++) begin
            read_expect($sformatf("reg_rdata ch%0d", order[i]),
                        make_addr(adc_pkg::ADDR_MAIN, order[i], adc_pkg::OFF_ADC_DATA),
                        patterns[order[i] - 1]);
        end
        finish_test("frame 0 data");

        wait_conv_rises(3);                   // Frame 1 replaces frame 0
        shuffle_channels();
        for (int i = 0; i < N; i++) begin
            read_expect($sformatf("reg_rdata ch%0d", order[i]),
                        make_addr(adc_pkg::ADDR_MAIN, order[i], adc_pkg::OFF_ADC_DATA),
                        patterns[N + order[i] - 1]);
        end
        finish_test("frame 1 data");

        read_reg(make_addr(adc_pkg::ADDR_MAIN, 0, adc_pkg::OFF_FRAME_COUNT), rdata);
        check_value("pot frame count", 32'(rdata[31:16]), 32'(conv_rises[0] - 1));
        check_value("current frame count", 32'(rdata[15:0]), 32'(conv_rises[1] - 1));
        finish_test("frame counts");

        read_expect("space 1", make_addr(4'h1, 1, adc_pkg::OFF_ADC_DATA), '0);
        read_expect("space 15", make_addr(4'hF, 0, adc_pkg::OFF_FRAME_COUNT), '0);
        read_expect("ch0 data offset", make_addr(adc_pkg::ADDR_MAIN, 0, adc_pkg::OFF_ADC_DATA), '0);
        for (int ch = 1; ch <= N; ch++) begin
            read_expect($sformatf("unused offset ch%0d", ch),
                        make_addr(adc_pkg::ADDR_MAIN, ch, 4'(1 + $urandom % 15)), '0);
        end
        for (int ch = N + 1; ch <= 15; ch++) begin
            read_expect($sformatf("reg_rdata ch%0d", ch),
                        make_addr(adc_pkg::ADDR_MAIN, ch, adc_pkg::OFF_ADC_DATA), '0);
        end
        finish_test("unmapped reads");

        $display("Tests: %0d passed, %0d failed, %0d mismatches",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/adc_patterns.hex ====
// One word per channel 1..8: pot word in bits 31:16, current word in bits 15:0
// Lines 1-8 frame 0, lines 9-16 frame 1 (repeated for every later frame)
// Frame 0
A5C31234
5A3C0F0F
FFFF0001
80007FFE
00018001
C0DEBEEF
13579BDF
7E812468
// Frame 1
3C5AE1D2
0000FFFF
98765432
FEDC0123
4B1D6A2F
84211248
DEADC0FF
0F1E2D3C

// ==== qla_adc_feedback.f ====
logic/adc_pkg.sv
logic/ltc1864_capture.sv
logic/adc_feedback_regs.sv
logic/adc_reg_read.sv
logic/qla_adc_feedback.sv
bench/ltc1864_model.sv
bench/qla_adc_feedback_sva.sv
bench/tb_qla_adc_feedback.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_qla_adc_feedback
FILELIST  ?= qla_adc_feedback.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		echo "sim: failure reported in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
